//--- sources.f
+incdir+rtl
rtl/gat_dbg_pkg.sv
rtl/stage_flag_tracker.sv
rtl/probe_capture.sv
rtl/debug_readout.sv
rtl/gat_debug_top.sv
test/tb_clk_gen.sv
test/tb_gat_debug.sv

//--- test/tb_gat_debug.sv
`timescale 1ns/10ps
`default_nettype none

`include "gat_dbg_defs.svh"

module tb_gat_debug;

  localparam int unsigned SEED          = 32'h504d7766;
  localparam realtime     CLK_PERIOD    = 4.0;
  localparam realtime     WATCHDOG_NS   = 200000.0;
  localparam int          RESET_TIMEOUT = 20;
  localparam logic [13:0] IDLE_WH       = 14'h3fff; // Matches no probe
  localparam logic [17:0] IDLE_H        = 18'h3ffff;

  logic clk;
  logic rst_n;
  logic dbg_clear;
  logic spmm_vld, spmm_rdy, dmvm_vld, dmvm_rdy;
  logic sm_vld, sm_rdy, aggr_vld, aggr_rdy;
  logic feat_ena;
  gat_dbg_pkg::hdata_addr_t h_addr;
  gat_dbg_pkg::hdata_word_t h_dout;
  gat_dbg_pkg::sppe_vec_t   sppe;
  gat_dbg_pkg::wh_addr_t    wh_addr;
  gat_dbg_pkg::feat_addr_t  feat_addr;
  gat_dbg_pkg::dbg_sel_e    dbg_sel;
  gat_dbg_pkg::dbg_word_t   dbg_word;

  // Expected state of the monitor
  gat_dbg_pkg::stage_flags_t exp_stage;
  logic [2:0]                exp_cap;   // {C, B, A}
  gat_dbg_pkg::sppe_word_t   exp_a;
  gat_dbg_pkg::sppe_word_t   exp_b;
  gat_dbg_pkg::hdata_word_t  exp_c;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RESET_CYCLES(3)) u_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  gat_debug_top u_gat_debug_top (
    .clk (clk), .rst_n (rst_n), .dbg_clear_i (dbg_clear),
    .spmm_vld_i (spmm_vld), .spmm_rdy_i (spmm_rdy),
    .dmvm_vld_i (dmvm_vld), .dmvm_rdy_i (dmvm_rdy),
    .sm_vld_i (sm_vld), .sm_rdy_i (sm_rdy),
    .aggr_vld_i (aggr_vld), .aggr_rdy_i (aggr_rdy),
    .h_data_bram_addrb_i (h_addr), .h_data_bram_dout_i (h_dout),
    .sppe_i (sppe), .wh_bram_addra_i (wh_addr),
    .feat_bram_ena_i (feat_ena), .feat_bram_addra_i (feat_addr),
    .dbg_sel_i (dbg_sel), .dbg_word_o (dbg_word)
  );

  // ************************************************************
  // Infrastructure
  // ************************************************************

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first error");
  endtask

  // One clock edge, bounded by two clock periods
  task automatic wait_clock_edge(input logic rising);
    fork
      begin
        if (rising) begin
          @(posedge clk);
        end else begin
          @(negedge clk);
        end
      end
      begin
        #(2.0 * CLK_PERIOD);
        abort_run("clock edge did not arrive in time");
      end
    join_any
    disable fork;
  endtask

  task automatic wait_edges(input int n);
    int i;
    for (i = 0; i < n; i++) begin
      wait_clock_edge(1'b1);
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (rst_n !== 1'b1) begin
      wait_clock_edge(1'b1);
      cycles++;
      if (cycles > RESET_TIMEOUT) abort_run("reset was never released");
    end
    wait_edges(1);
  endtask

  task automatic model_reset();
    exp_stage = '0;
    exp_cap   = '0;
    exp_a     = '0;
    exp_b     = '0;
    exp_c     = '0;
  endtask

  function automatic gat_dbg_pkg::dbg_word_t flags_model();
    return {19'd0, exp_cap, 2'b00, exp_stage};
  endfunction

  // Select a word and sample it two edges later
  task automatic read_word(input gat_dbg_pkg::dbg_sel_e sel,
                           output gat_dbg_pkg::dbg_word_t word);
    wait_edges(1);
    dbg_sel <= sel;
    wait_edges(2);
    wait_clock_edge(1'b0);
    word = dbg_word;
  endtask

  task automatic compare_word(input string test_name, input gat_dbg_pkg::dbg_sel_e sel,
                              input gat_dbg_pkg::dbg_word_t expected);
    gat_dbg_pkg::dbg_word_t actual;
    read_word(sel, actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %s %s expected 0x%08h actual 0x%08h",
                          test_name, sel.name(), expected, actual));
    end
  endtask

  task automatic compare_flags(input string test_name,
                               input gat_dbg_pkg::stage_flags_t expected);
    gat_dbg_pkg::dbg_word_t    word;
    gat_dbg_pkg::stage_flags_t actual;
    read_word(gat_dbg_pkg::DBG_FLAGS, word);
    actual = gat_dbg_pkg::stage_flags_t'(word[7:0]);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch %s expected 0x%02h actual 0x%02h",
                          test_name, expected, actual));
    end
  endtask

  // ************************************************************
  // Drive tasks
  // ************************************************************

  task automatic drive_strobes(input gat_dbg_pkg::stage_flags_t s);
    spmm_vld <= s.spmm_vld;
    spmm_rdy <= s.spmm_rdy;
    dmvm_vld <= s.dmvm_vld;
    dmvm_rdy <= s.dmvm_rdy;
    sm_vld   <= s.sm_vld;
    sm_rdy   <= s.sm_rdy;
    aggr_vld <= s.aggr_vld;
    aggr_rdy <= s.aggr_rdy;
  endtask

  task automatic pulse_strobes(input gat_dbg_pkg::stage_flags_t s);
    wait_edges(1);
    drive_strobes(s);
    exp_stage = exp_stage | s;
    wait_edges(1);
    drive_strobes('0);
  endtask

  task automatic pulse_clear();
    wait_edges(1);
    dbg_clear <= 1'b1;
    wait_edges(1);
    dbg_clear <= 1'b0;
    model_reset();
  endtask

  task automatic feat_write(input gat_dbg_pkg::feat_addr_t addr);
    wait_edges(1);
    feat_ena  <= 1'b1;
    feat_addr <= addr;
    wait_edges(1);
    feat_ena  <= 1'b0;
  endtask

  // One cycle on the probe ports, expected values follow the capture rule
  task automatic probe_cycle(input gat_dbg_pkg::wh_addr_t wh, input logic rdy,
                             input gat_dbg_pkg::sppe_word_t lane,
                             input gat_dbg_pkg::hdata_addr_t ha, input logic vld,
                             input gat_dbg_pkg::hdata_word_t hd);
    gat_dbg_pkg::sppe_vec_t vec;
    int                     l;
    for (l = 0; l < `GAT_SPPE_LANES; l++) begin
      vec[l] = gat_dbg_pkg::sppe_word_t'($urandom);
    end
    vec[`GAT_PROBE_LANE] = lane;
    wait_edges(1);
    wh_addr  <= wh;
    spmm_rdy <= rdy;
    sppe     <= vec;
    h_addr   <= ha;
    spmm_vld <= vld;
    h_dout   <= hd;
    exp_stage.spmm_rdy = exp_stage.spmm_rdy | rdy;
    exp_stage.spmm_vld = exp_stage.spmm_vld | vld;
    if (rdy && wh == gat_dbg_pkg::wh_addr_t'(`GAT_PROBE_ADDR_A)) begin
      exp_a      = lane;
      exp_cap[0] = 1'b1;
    end
    if (rdy && wh == gat_dbg_pkg::wh_addr_t'(`GAT_PROBE_ADDR_B)) begin
      exp_b      = lane;
      exp_cap[1] = 1'b1;
    end
    if (vld && ha == gat_dbg_pkg::hdata_addr_t'(`GAT_HDATA_PROBE_ADDR)) begin
      exp_c      = hd;
      exp_cap[2] = 1'b1;
    end
  endtask

  task automatic probe_idle();
    wait_edges(1);
    spmm_rdy <= 1'b0;
    spmm_vld <= 1'b0;
    wh_addr  <= IDLE_WH;
    h_addr   <= IDLE_H;
  endtask

  // ************************************************************
  // Tests
  // ************************************************************

  task automatic test_reset();
    compare_word("reset", gat_dbg_pkg::DBG_ID, `GAT_DBG_SIGNATURE);
    compare_word("reset", gat_dbg_pkg::DBG_CONFIG, 32'd12);
    compare_word("reset", gat_dbg_pkg::DBG_FLAGS, '0);
    compare_word("reset", gat_dbg_pkg::DBG_SM_COUNT_LO, '0);
    compare_word("reset", gat_dbg_pkg::DBG_SM_COUNT_HI, '0);
  endtask

  task automatic test_stage_flags();
    gat_dbg_pkg::stage_flags_t mask;
    int                        round;
    pulse_clear();
    for (round = 0; round < 4; round++) begin
      mask = gat_dbg_pkg::stage_flags_t'($urandom_range(255, 1));
      pulse_strobes(mask);
      compare_flags("stage_flags", exp_stage);
    end
    wait_edges(5);
    compare_flags("stage_flags_hold", exp_stage); // Strobes long gone
  endtask

  task automatic test_sm_count();
    int n;
    pulse_clear();
    n = $urandom_range(300, 1);
    wait_edges(1);
    sm_vld <= 1'b1;
    wait_edges(n); // n edges sample the level high
    sm_vld <= 1'b0;
    compare_word("sm_count", gat_dbg_pkg::DBG_SM_COUNT_LO, gat_dbg_pkg::dbg_word_t'(n));
    compare_word("sm_count", gat_dbg_pkg::DBG_SM_COUNT_HI, '0);
  endtask

  task automatic test_probes();
    gat_dbg_pkg::wh_addr_t    wh;
    gat_dbg_pkg::hdata_addr_t ha;
    int                       i;
    pulse_clear();
    probe_cycle(`GAT_PROBE_ADDR_A, 1'b1, 12'h5a1, IDLE_H, 1'b0, '0);
    probe_cycle(`GAT_PROBE_ADDR_A, 1'b0, 12'h0f3, IDLE_H, 1'b0, '0);
    probe_cycle(14'd11, 1'b1, 12'h777, IDLE_H, 1'b0, '0);
    probe_cycle(`GAT_PROBE_ADDR_B, 1'b1, 12'hc3c, IDLE_H, 1'b0, '0);
    probe_cycle(IDLE_WH, 1'b0, '0, `GAT_HDATA_PROBE_ADDR, 1'b1, 19'h5_1234);
    probe_cycle(IDLE_WH, 1'b0, '0, `GAT_HDATA_PROBE_ADDR, 1'b0, 19'h7_0f0f);
    probe_cycle(IDLE_WH, 1'b0, '0, 18'd5, 1'b1, 19'h2_aaaa);
    for (i = 0; i < 40; i++) begin
      case ($urandom_range(2, 0))
        0:       wh = gat_dbg_pkg::wh_addr_t'(`GAT_PROBE_ADDR_A);
        1:       wh = gat_dbg_pkg::wh_addr_t'(`GAT_PROBE_ADDR_B);
        default: wh = gat_dbg_pkg::wh_addr_t'($urandom);
      endcase
      ha = $urandom_range(1, 0) ? gat_dbg_pkg::hdata_addr_t'(`GAT_HDATA_PROBE_ADDR)
                                : gat_dbg_pkg::hdata_addr_t'($urandom);
      probe_cycle(wh, 1'($urandom), gat_dbg_pkg::sppe_word_t'($urandom),
                  ha, 1'($urandom), gat_dbg_pkg::hdata_word_t'($urandom));
    end
    probe_idle();
    compare_word("probes", gat_dbg_pkg::DBG_PROBE_A, gat_dbg_pkg::dbg_word_t'(exp_a));
    compare_word("probes", gat_dbg_pkg::DBG_PROBE_B, gat_dbg_pkg::dbg_word_t'(exp_b));
    compare_word("probes", gat_dbg_pkg::DBG_PROBE_C, gat_dbg_pkg::dbg_word_t'(exp_c));
    compare_word("probes", gat_dbg_pkg::DBG_FLAGS, flags_model());
  endtask

  task automatic test_feat_writes();
    int i;
    pulse_clear();
    wait_edges(1);
    feat_addr <= 16'hffff; // Enable stays low
    compare_word("feat_idle", gat_dbg_pkg::DBG_FLAGS, '0);
    for (i = 0; i < 5; i++) begin
      feat_write(gat_dbg_pkg::feat_addr_t'($urandom_range(`GAT_FEAT_ADDR_LIMIT - 1, 0)));
    end
    compare_word("feat_below", gat_dbg_pkg::DBG_FLAGS, 32'h0000_0100);
    feat_write(gat_dbg_pkg::feat_addr_t'(`GAT_FEAT_ADDR_LIMIT));
    compare_word("feat_limit", gat_dbg_pkg::DBG_FLAGS, 32'h0000_0300);
  endtask

  task automatic test_clear();
    int s;
    pulse_strobes('1);
    probe_cycle(`GAT_PROBE_ADDR_A, 1'b1, 12'h9e7, `GAT_HDATA_PROBE_ADDR, 1'b1, 19'h6_5432);
    probe_cycle(`GAT_PROBE_ADDR_B, 1'b1, 12'h3b5, IDLE_H, 1'b0, '0);
    probe_idle();
    feat_write(gat_dbg_pkg::feat_addr_t'(`GAT_FEAT_ADDR_LIMIT));
    pulse_clear();
    compare_word("clear", gat_dbg_pkg::DBG_ID, `GAT_DBG_SIGNATURE);
    compare_word("clear", gat_dbg_pkg::DBG_CONFIG, 32'd12);
    for (s = 2; s < 8; s++) begin
      compare_word("clear", gat_dbg_pkg::dbg_sel_e'(s), '0);
    end
    // Clear and events in the same cycle
    wait_edges(1);
    dbg_clear <= 1'b1;
    drive_strobes('1);
    feat_ena  <= 1'b1;
    feat_addr <= gat_dbg_pkg::feat_addr_t'(`GAT_FEAT_ADDR_LIMIT);
    wait_edges(1);
    dbg_clear <= 1'b0;
    drive_strobes('0);
    feat_ena  <= 1'b0;
    compare_word("clear_wins", gat_dbg_pkg::DBG_FLAGS, '0);
    compare_word("clear_wins", gat_dbg_pkg::DBG_SM_COUNT_LO, '0);
  endtask

  // ************************************************************
  // Sequence
  // ************************************************************

  initial begin
    void'($urandom(SEED));
    dbg_clear = 1'b0;
    drive_strobes('0);
    feat_ena  = 1'b0;
    feat_addr = '0;
    h_addr    = IDLE_H;
    h_dout    = '0;
    sppe      = '0;
    wh_addr   = IDLE_WH;
    dbg_sel   = gat_dbg_pkg::DBG_ID;
    model_reset();
    wait_reset_release();
    test_reset();
    test_stage_flags();
    test_sm_count();
    test_probes();
    test_feat_writes();
    test_clear();
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the test sequence finished");
  end

endmodule

`default_nettype wire

//--- test/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
  parameter realtime PERIOD_NS    = 4.0,
  parameter int      RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1; // Released on a rising edge
  end

endmodule

`default_nettype wire

//--- rtl/gat_debug_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "gat_dbg_defs.svh"

module gat_debug_top (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  input  wire logic                      dbg_clear_i,
  input  wire logic                      spmm_vld_i,
  input  wire logic                      spmm_rdy_i,
  input  wire logic                      dmvm_vld_i,
  input  wire logic                      dmvm_rdy_i,
  input  wire logic                      sm_vld_i,
  input  wire logic                      sm_rdy_i,
  input  wire logic                      aggr_vld_i,
  input  wire logic                      aggr_rdy_i,
  input  wire gat_dbg_pkg::hdata_addr_t  h_data_bram_addrb_i,
  input  wire gat_dbg_pkg::hdata_word_t  h_data_bram_dout_i,
  input  wire gat_dbg_pkg::sppe_vec_t    sppe_i,
  input  wire gat_dbg_pkg::wh_addr_t     wh_bram_addra_i,
  input  wire logic                      feat_bram_ena_i,
  input  wire gat_dbg_pkg::feat_addr_t   feat_bram_addra_i,
  input  wire gat_dbg_pkg::dbg_sel_e     dbg_sel_i,
  output gat_dbg_pkg::dbg_word_t         dbg_word_o
);

  gat_dbg_pkg::stage_flags_t       stage_flags;
  logic                            feat_wr_seen;
  logic                            feat_overflow;
  logic [`GAT_SM_COUNT_WIDTH-1:0]  sm_count;
  gat_dbg_pkg::sppe_word_t         probe_a_value;
  gat_dbg_pkg::sppe_word_t         probe_b_value;
  gat_dbg_pkg::hdata_word_t        probe_c_value;
  logic [2:0]                      probe_captured; // {C, B, A}

  // ************************************************************
  // Flag tracker
  // ************************************************************

  stage_flag_tracker u_tracker (
    .clk             (clk),
    .rst_n           (rst_n),
    .clear_i         (dbg_clear_i),
    .spmm_vld_i      (spmm_vld_i),
    .spmm_rdy_i      (spmm_rdy_i),
    .dmvm_vld_i      (dmvm_vld_i),
    .dmvm_rdy_i      (dmvm_rdy_i),
    .sm_vld_i        (sm_vld_i),
    .sm_rdy_i        (sm_rdy_i),
    .aggr_vld_i      (aggr_vld_i),
    .aggr_rdy_i      (aggr_rdy_i),
    .feat_ena_i      (feat_bram_ena_i),
    .feat_addr_i     (feat_bram_addra_i),
    .stage_flags_o   (stage_flags),
    .feat_wr_seen_o  (feat_wr_seen),
    .feat_overflow_o (feat_overflow),
    .sm_count_o      (sm_count)
  );

  // ************************************************************
  // Probes
  // ************************************************************

  // A and B watch one spmm lane at weighted-h addresses
  probe_capture #(
    .payload_t (gat_dbg_pkg::sppe_word_t),
    .addr_t    (gat_dbg_pkg::wh_addr_t),
    .TRIG_ADDR (gat_dbg_pkg::wh_addr_t'(`GAT_PROBE_ADDR_A))
  ) u_probe_a (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (dbg_clear_i),
    .strobe_i   (spmm_rdy_i),
    .addr_i     (wh_bram_addra_i),
    .payload_i  (sppe_i[`GAT_PROBE_LANE]),
    .value_o    (probe_a_value),
    .captured_o (probe_captured[0])
  );

  probe_capture #(
    .payload_t (gat_dbg_pkg::sppe_word_t),
    .addr_t    (gat_dbg_pkg::wh_addr_t),
    .TRIG_ADDR (gat_dbg_pkg::wh_addr_t'(`GAT_PROBE_ADDR_B))
  ) u_probe_b (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (dbg_clear_i),
    .strobe_i   (spmm_rdy_i),
    .addr_i     (wh_bram_addra_i),
    .payload_i  (sppe_i[`GAT_PROBE_LANE]),
    .value_o    (probe_b_value),
    .captured_o (probe_captured[1])
  );

  probe_capture #(
    .payload_t (gat_dbg_pkg::hdata_word_t),
    .addr_t    (gat_dbg_pkg::hdata_addr_t),
    .TRIG_ADDR (gat_dbg_pkg::hdata_addr_t'(`GAT_HDATA_PROBE_ADDR))
  ) u_probe_c (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear_i    (dbg_clear_i),
    .strobe_i   (spmm_vld_i),     // h-data reads happen during spmm
    .addr_i     (h_data_bram_addrb_i),
    .payload_i  (h_data_bram_dout_i),
    .value_o    (probe_c_value),
    .captured_o (probe_captured[2])
  );

  // ************************************************************
  // Readout
  // ************************************************************

  debug_readout u_readout (
    .clk              (clk),
    .rst_n            (rst_n),
    .sel_i            (dbg_sel_i),
    .stage_flags_i    (stage_flags),
    .feat_wr_seen_i   (feat_wr_seen),
    .feat_overflow_i  (feat_overflow),
    .sm_count_i       (sm_count),
    .probe_a_i        (probe_a_value),
    .probe_b_i        (probe_b_value),
    .probe_c_i        (probe_c_value),
    .probe_captured_i (probe_captured),
    .dbg_word_o       (dbg_word_o)
  );

endmodule

`default_nettype wire

//--- rtl/debug_readout.sv
`timescale 1ns/10ps
`default_nettype none

`include "gat_dbg_defs.svh"

module debug_readout (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire gat_dbg_pkg::dbg_sel_e          sel_i,
  input  wire gat_dbg_pkg::stage_flags_t      stage_flags_i,
  input  wire logic                           feat_wr_seen_i,
  input  wire logic                           feat_overflow_i,
  input  wire logic [`GAT_SM_COUNT_WIDTH-1:0] sm_count_i,
  input  wire gat_dbg_pkg::sppe_word_t        probe_a_i,
  input  wire gat_dbg_pkg::sppe_word_t        probe_b_i,
  input  wire gat_dbg_pkg::hdata_word_t       probe_c_i,
  input  wire logic [2:0]                     probe_captured_i,
  output gat_dbg_pkg::dbg_word_t              dbg_word_o
);

  localparam int unsigned CW = `GAT_SM_COUNT_WIDTH;

  gat_dbg_pkg::dbg_word_t id_word;
  gat_dbg_pkg::dbg_word_t config_word;
  gat_dbg_pkg::dbg_word_t flags_word;
  gat_dbg_pkg::dbg_word_t count_lo_word;
  gat_dbg_pkg::dbg_word_t count_hi_word;
  gat_dbg_pkg::dbg_word_t probe_a_word;
  gat_dbg_pkg::dbg_word_t probe_b_word;
  gat_dbg_pkg::dbg_word_t probe_c_word;
  gat_dbg_pkg::dbg_word_t word_mux;
  gat_dbg_pkg::dbg_word_t dbg_word_q;

  // ************************************************************
  // Word assembly
  // ************************************************************

  assign id_word     = `GAT_DBG_SIGNATURE;
  assign config_word = `GAT_H_NUM_SPARSE_DATA;

  // Captured bits in 12:10, probe A lowest
  assign flags_word = {19'd0, probe_captured_i, feat_overflow_i, feat_wr_seen_i,
                       stage_flags_i};

  assign count_lo_word = sm_count_i[31:0];
  assign count_hi_word = gat_dbg_pkg::dbg_word_t'(sm_count_i[CW-1:32]);

  assign probe_a_word = gat_dbg_pkg::dbg_word_t'(probe_a_i); // Zero-extended
  assign probe_b_word = gat_dbg_pkg::dbg_word_t'(probe_b_i);
  assign probe_c_word = gat_dbg_pkg::dbg_word_t'(probe_c_i);

  always_comb begin
    case (sel_i)
      gat_dbg_pkg::DBG_ID:          word_mux = id_word;
      gat_dbg_pkg::DBG_CONFIG:      word_mux = config_word;
      gat_dbg_pkg::DBG_FLAGS:       word_mux = flags_word;
      gat_dbg_pkg::DBG_SM_COUNT_LO: word_mux = count_lo_word;
      gat_dbg_pkg::DBG_SM_COUNT_HI: word_mux = count_hi_word;
      gat_dbg_pkg::DBG_PROBE_A:     word_mux = probe_a_word;
      gat_dbg_pkg::DBG_PROBE_B:     word_mux = probe_b_word;
      gat_dbg_pkg::DBG_PROBE_C:     word_mux = probe_c_word;
      default:                      word_mux = '0;
    endcase
  end

  // ************************************************************
  // Output register
  // ************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dbg_word_q <= '0;
    end else begin
      dbg_word_q <= word_mux;
    end
  end

  assign dbg_word_o = dbg_word_q;

  // ************************************************************
  // Checks
  // ************************************************************

  a_sel_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown(sel_i)
  );

endmodule

`default_nettype wire

//--- rtl/probe_capture.sv
`timescale 1ns/10ps
`default_nettype none

module probe_capture #(
  parameter type   payload_t = logic [7:0],
  parameter type   addr_t    = logic [7:0],
  parameter addr_t TRIG_ADDR = '0
) (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic clear_i,
  input  wire logic strobe_i,
  input  wire addr_t    addr_i,
  input  wire payload_t payload_i,
  output payload_t      value_o,
  output logic          captured_o
);

  payload_t value_q;
  logic     captured_q;
  logic     hit;

  // Trigger address seen while the strobe is up
  assign hit = strobe_i && (addr_i == TRIG_ADDR);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      value_q    <= payload_t'('0);
      captured_q <= 1'b0;
    end else if (clear_i) begin
      value_q    <= payload_t'('0);
      captured_q <= 1'b0;
    end else if (hit) begin
      value_q    <= payload_i; // Later match overwrites
      captured_q <= 1'b1;
    end
  end

  assign value_o    = value_q;
  assign captured_o = captured_q;

  // ************************************************************
  // Checks
  // ************************************************************

  a_payload_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    (hit && !clear_i) |-> !$isunknown(payload_i)
  );

endmodule

`default_nettype wire

//--- rtl/stage_flag_tracker.sv
`timescale 1ns/10ps
`default_nettype none

`include "gat_dbg_defs.svh"

module stage_flag_tracker (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           clear_i,
  input  wire logic                           spmm_vld_i,
  input  wire logic                           spmm_rdy_i,
  input  wire logic                           dmvm_vld_i,
  input  wire logic                           dmvm_rdy_i,
  input  wire logic                           sm_vld_i,
  input  wire logic                           sm_rdy_i,
  input  wire logic                           aggr_vld_i,
  input  wire logic                           aggr_rdy_i,
  input  wire logic                           feat_ena_i,
  input  wire gat_dbg_pkg::feat_addr_t        feat_addr_i,
  output gat_dbg_pkg::stage_flags_t           stage_flags_o,
  output logic                                feat_wr_seen_o,
  output logic                                feat_overflow_o,
  output logic [`GAT_SM_COUNT_WIDTH-1:0]      sm_count_o
);

  localparam int unsigned CW = `GAT_SM_COUNT_WIDTH;

  gat_dbg_pkg::stage_flags_t stage_hits;
  gat_dbg_pkg::stage_flags_t stage_flags_q;
  logic                      feat_wr_seen_q;
  logic                      feat_overflow_q;
  logic                      feat_out_of_range;
  logic [CW-1:0]             sm_count_q;
  logic [9:0]                sticky_bits;

  // ************************************************************
  // Sticky flags
  // ************************************************************

  assign stage_hits = {spmm_vld_i, spmm_rdy_i, dmvm_vld_i, dmvm_rdy_i,
                       sm_vld_i, sm_rdy_i, aggr_vld_i, aggr_rdy_i};

  assign feat_out_of_range =
    (feat_addr_i >= gat_dbg_pkg::feat_addr_t'(`GAT_FEAT_ADDR_LIMIT));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_flags_q   <= '0;
      feat_wr_seen_q  <= 1'b0;
      feat_overflow_q <= 1'b0;
    end else if (clear_i) begin // Clear beats a same-cycle set
      stage_flags_q   <= '0;
      feat_wr_seen_q  <= 1'b0;
      feat_overflow_q <= 1'b0;
    end else begin
      stage_flags_q <= stage_flags_q | stage_hits;
      if (feat_ena_i) begin
        feat_wr_seen_q <= 1'b1;
      end
      if (feat_ena_i && feat_out_of_range) begin
        feat_overflow_q <= 1'b1;
      end
    end
  end

  // ************************************************************
  // Softmax valid cycle counter
  // ************************************************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sm_count_q <= '0;
    end else if (clear_i) begin
      sm_count_q <= '0;
    end else if (sm_vld_i) begin
      sm_count_q <= sm_count_q + CW'(1); // Wraps at full width
    end
  end

  assign stage_flags_o   = stage_flags_q;
  assign feat_wr_seen_o  = feat_wr_seen_q;
  assign feat_overflow_o = feat_overflow_q;
  assign sm_count_o      = sm_count_q;

  // ************************************************************
  // Checks
  // ************************************************************

  assign sticky_bits = {stage_flags_q, feat_wr_seen_q, feat_overflow_q};

  // Set bits only fall through a clear
  a_sticky_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    !clear_i |=> ((sticky_bits & $past(sticky_bits)) == $past(sticky_bits))
  );

  a_count_monotonic : assert property (
    @(posedge clk) disable iff (!rst_n)
    (!clear_i && !(&sm_count_q)) |=> (sm_count_q >= $past(sm_count_q))
  );

endmodule

`default_nettype wire

//--- rtl/gat_dbg_pkg.sv
`default_nettype none

`include "gat_dbg_defs.svh"

package gat_dbg_pkg;

  // Sparse PE lane results
  typedef logic [`GAT_SPPE_WIDTH-1:0] sppe_word_t;
  typedef logic [`GAT_SPPE_LANES-1:0][`GAT_SPPE_WIDTH-1:0] sppe_vec_t;

  // Memory ports seen by the monitor
  typedef logic [18:0] hdata_word_t;
  typedef logic [17:0] hdata_addr_t;
  typedef logic [13:0] wh_addr_t;
  typedef logic [15:0] feat_addr_t;

  typedef logic [31:0] dbg_word_t;

  // Sticky stage bits, spmm_vld is the MSB
  typedef struct packed {
    logic spmm_vld;
    logic spmm_rdy;
    logic dmvm_vld;
    logic dmvm_rdy;
    logic sm_vld;
    logic sm_rdy;
    logic aggr_vld;
    logic aggr_rdy;
  } stage_flags_t;

  // Readout word selector
  typedef enum logic [2:0] {
    DBG_ID          = 3'd0,
    DBG_CONFIG      = 3'd1,
    DBG_FLAGS       = 3'd2,
    DBG_SM_COUNT_LO = 3'd3,
    DBG_SM_COUNT_HI = 3'd4,
    DBG_PROBE_A     = 3'd5,
    DBG_PROBE_B     = 3'd6,
    DBG_PROBE_C     = 3'd7
  } dbg_sel_e;

endpackage

`default_nettype wire

//--- rtl/gat_dbg_defs.svh
`ifndef GAT_DBG_DEFS_SVH
`define GAT_DBG_DEFS_SVH

// ************************************************************
// Identity and configuration words
// ************************************************************
`define GAT_DBG_SIGNATURE     32'd21072204
`define GAT_H_NUM_SPARSE_DATA 32'd12

// ************************************************************
// Sparse PE array geometry
// ************************************************************
`define GAT_SPPE_LANES 16
`define GAT_SPPE_WIDTH 12

// ************************************************************
// Probe triggers
// ************************************************************
`define GAT_PROBE_LANE       2
`define GAT_PROBE_ADDR_A     10   // Weighted-h address
`define GAT_PROBE_ADDR_B     20   // Weighted-h address
`define GAT_HDATA_PROBE_ADDR 0

// First feature address past the feature region
`define GAT_FEAT_ADDR_LIMIT 43328

// Softmax valid cycle counter
`define GAT_SM_COUNT_WIDTH 48

`endif
